// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module tbOutputPort -o simv
	./obj_dir/simv

clean:
	rm -rf obj_dir

// File: files.f
rtl/nocPkg.sv
rtl/flitLinkIf.sv
rtl/flitFifo.sv
rtl/holdTimer.sv
rtl/outputArbiter.sv
rtl/outputPort.sv
tests/outputPort_assert.sv
tests/tbOutputPort.sv

// File: rtl/flitFifo.sv
`timescale 1ns/10ps
`default_nettype none

module flitFifo import nocPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  flitLinkIf.sink   enq,
  flitLinkIf.source deq
);

  flitId            idMem   [fifoDepth];
  flitData          dataMem [fifoDepth];
  logic [ptrW-1:0]  wrPtr;
  logic [ptrW-1:0]  rdPtr;
  logic [cntW-1:0]  fill;  // Entries held
  logic             push;
  logic             pop;

  assign push = enq.valid && enq.ready;
  assign pop  = deq.valid && deq.ready;

  assign enq.ready = (fill != cntW'(fifoDepth));  // Back-pressure when full
  assign deq.valid = (fill != '0);
  assign deq.id    = idMem[rdPtr];
  assign deq.data  = dataMem[rdPtr];

  // Storage
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      idMem[wrPtr]   <= enq.id;
      dataMem[wrPtr] <= enq.data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill  <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= (wrPtr == ptrW'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == ptrW'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;  // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/flitLinkIf.sv
`timescale 1ns/10ps
`default_nettype none

interface flitLinkIf import nocPkg::*; ();

  logic    valid;  // Held until accepted
  logic    ready;
  flitId   id;
  flitData data;

  modport source
  (
    output valid,
    output id,
    output data,
    input  ready
  );

  modport sink
  (
    input  valid,
    input  id,
    input  data,
    output ready
  );

endinterface

`default_nettype wire

// File: rtl/holdTimer.sv
`timescale 1ns/10ps
`default_nettype none

module holdTimer import nocPkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   headSent,
  input  holdLen length,
  input  logic   granted,
  output logic   expired
);

  holdLen budget;  // Length of the last head flit
  holdLen count;   // Granted cycles since then

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count  <= '0;
    end
    else
    begin
      if (headSent)
      begin
        budget <= length;
        count  <= '0;
      end
      else if (granted)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // Zero budget expires on first granted cycle
  assign expired = (count == budget);

endmodule

`default_nettype wire

// File: rtl/nocPkg.sv
`default_nettype none

package nocPkg;

  // Router geometry
  localparam int numPorts  = 5;
  localparam int fifoDepth = 4;

  // FIFO pointer and fill counter widths
  localparam int ptrW = $clog2(fifoDepth);
  localparam int cntW = $clog2(fifoDepth + 1);

  // Flit fields
  typedef logic [2:0]  flitId;
  typedef logic [15:0] flitData;
  typedef logic [11:0] holdLen;  // Hold budget in cycles, head data 11..0

  // Port numbering: Local 0, North 1, East 2, West 3, South 4
  typedef logic [2:0] portIdx;

  // Flit kinds
  localparam flitId idHead = 3'd1;  // Data carries the length
  localparam flitId idBody = 3'd2;
  localparam flitId idTail = 3'd4;

  // Grant FSM, one-hot, bit 0 is idle
  typedef enum logic [numPorts:0] {
    stIdle  = 6'b000001,
    stLocal = 6'b000010,
    stNorth = 6'b000100,
    stEast  = 6'b001000,
    stWest  = 6'b010000,
    stSouth = 6'b100000
  } arbState;

endpackage

`default_nettype wire

// File: rtl/outputArbiter.sv
`timescale 1ns/10ps
`default_nettype none

module outputArbiter import nocPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  flitLinkIf.sink req [numPorts],
  output logic    outValid,
  input  logic    outReady,
  output flitId   outId,
  output flitData outData
);

  arbState               state;
  arbState               nextState;
  logic [numPorts-1:0]   grant;     // One-hot, zero in idle
  logic [numPorts-1:0]   reqValid;
  logic [numPorts-1:0]   expired;
  logic [numPorts-1:0]   headSent;
  flitId                 reqId   [numPorts];
  flitData               reqData [numPorts];
  portIdx                grantIdx;
  portIdx                nextIdx;

  // State that grants the given port
  function automatic arbState stateOf(input int pos);
    return arbState'(6'b000010 << pos);
  endfunction

  // First set bit of mask in cyclic order from start
  function automatic arbState scan(input portIdx start, input logic [numPorts-1:0] mask);
    arbState pick;
    int      pos;
    pick = stIdle;
    for (int k = numPorts - 1; k >= 0; k--)
    begin
      pos = (int'(start) + k) % numPorts;
      if (mask[pos])
        pick = stateOf(pos);  // Earlier positions overwrite later ones
    end
    return pick;
  endfunction

  // Per-port link handling and hold timers
  for (genvar i = 0; i < numPorts; i++)
  begin : g_port
    assign reqValid[i]  = req[i].valid;
    assign reqId[i]     = req[i].id;
    assign reqData[i]   = req[i].data;
    assign req[i].ready = grant[i] & outReady;  // Pop only the granted FIFO

    assign headSent[i] = grant[i] && reqValid[i] && outReady && (reqId[i] == idHead);

    holdTimer i_timer
    (
      .clk      (clk),
      .rst      (rst),
      .headSent (headSent[i]),
      .length   (holdLen'(reqData[i][11:0])),
      .granted  (grant[i]),
      .expired  (expired[i])
    );
  end

  assign grant = state[numPorts:1];

  always_comb
  begin
    grantIdx = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
        grantIdx = portIdx'(i);
    end
  end

  assign nextIdx = portIdx'((int'(grantIdx) + 1) % numPorts);

  // Output mux
  assign outValid = |(grant & reqValid);
  assign outId    = reqId[grantIdx];
  assign outData  = reqData[grantIdx];

  always_comb
  begin
    nextState = stIdle;
    case (state)
      stIdle:
        nextState = scan('0, reqValid);  // Fixed priority, Local first
      stLocal, stNorth, stEast, stWest, stSouth:
      begin
        if (reqValid[grantIdx] && !expired[grantIdx])
          nextState = state;  // Keep the worm going
        else
          nextState = scan(nextIdx, reqValid & ~grant);
      end
      default:
        nextState = stIdle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stIdle;
    else
      state <= nextState;
  end

endmodule

`default_nettype wire

// File: rtl/outputPort.sv
`timescale 1ns/10ps
`default_nettype none

module outputPort import nocPkg::*;
(
  input  logic                clk,
  input  logic                rst,

  // Input links, one per port
  input  logic [numPorts-1:0] inValid,
  output logic [numPorts-1:0] inReady,
  input  flitId               inId   [numPorts],
  input  flitData             inData [numPorts],

  // Output link
  output logic                outValid,
  input  logic                outReady,
  output flitId               outId,
  output flitData             outData
);

  flitLinkIf inLink   [numPorts] ();  // Top ports to FIFOs
  flitLinkIf fifoLink [numPorts] ();  // FIFOs to arbiter

  for (genvar i = 0; i < numPorts; i++)
  begin : g_in
    assign inLink[i].valid = inValid[i];
    assign inLink[i].id    = inId[i];
    assign inLink[i].data  = inData[i];
    assign inReady[i]      = inLink[i].ready;

    flitFifo i_fifo
    (
      .clk (clk),
      .rst (rst),
      .enq (inLink[i]),
      .deq (fifoLink[i])
    );
  end

  outputArbiter i_arbiter
  (
    .clk      (clk),
    .rst      (rst),
    .req      (fifoLink),
    .outValid (outValid),
    .outReady (outReady),
    .outId    (outId),
    .outData  (outData)
  );

endmodule

`default_nettype wire

// File: tests/outputPort_assert.sv
`timescale 1ns/10ps
`default_nettype none

module arbiterChecks import nocPkg::*;
(
  input logic                clk,
  input logic                rst,
  input arbState             state,
  input arbState             nextState,
  input logic [numPorts-1:0] grant,
  input logic [numPorts-1:0] reqReady,
  input logic                outValid,
  input logic                outReady,
  input flitId               outId,
  input flitData             outData
);

  a_oneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("arbiter state is not one-hot");

  // Same grant and no pop keeps the same FIFO head
  a_holdFlit: assert property (@(posedge clk) disable iff (rst)
    (outValid && !outReady && nextState == state)
      |=> (outValid && $stable(outId) && $stable(outData)))
    else $error("output flit changed while stalled under the same grant");

  a_readyGranted: assert property (@(posedge clk) disable iff (rst)
    (reqReady & ~grant) == '0)
    else $error("ready given to a port without the grant");

endmodule

bind outputArbiter arbiterChecks i_arbiterChecks
(
  .clk       (clk),
  .rst       (rst),
  .state     (state),
  .nextState (nextState),
  .grant     (grant),
  .reqReady  ({req[4].ready, req[3].ready, req[2].ready, req[1].ready, req[0].ready}),
  .outValid  (outValid),
  .outReady  (outReady),
  .outId     (outId),
  .outData   (outData)
);

`default_nettype wire

// File: tests/tbOutputPort.sv
`timescale 1ns/10ps
`default_nettype none

module tbOutputPort import nocPkg::*; ();

  logic                clk;
  logic                rst;
  logic [numPorts-1:0] inValid;
  logic [numPorts-1:0] inReady;
  flitId               inId   [numPorts];
  flitData             inData [numPorts];
  logic                outValid;
  logic                outReady;
  flitId               outId;
  flitData             outData;

  integer              seed;
  logic                genOn;                // New flits allowed
  logic [numPorts-1:0] taken;                // Input handshake at the coming edge
  int                  left   [numPorts];    // Flits still due in the current packet
  logic [12:0]         seqNo  [numPorts];
  logic [18:0]         expQ   [numPorts][$]; // {id, data} in send order
  int                  occ    [numPorts];    // Flits held in each FIFO
  holdLen              headLen[numPorts];    // Length of the last head seen at the output
  logic [numPorts-1:0] lastMask;
  logic [numPorts-1:0] prevMask;
  int                  lastSrc;
  int                  runLen;
  logic                headInRun;            // Current run counted from a head
  logic                stalled;              // outReady dropped since the last transfer

  outputPort i_outputPort
  (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inReady  (inReady),
    .inId     (inId),
    .inData   (inData),
    .outValid (outValid),
    .outReady (outReady),
    .outId    (outId),
    .outData  (outData)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic endRun(input string line);
    $display("%s", line);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic reportMismatch(input string msg);
    endRun($sformatf("Fail %0t: %s", $time, msg));
  endtask

  // True if a port strictly between from and to, cyclically, is set in m
  function automatic logic skipped(input int from, input int to, input logic [numPorts-1:0] m);
    logic hit;
    int   r;
    hit = 1'b0;
    r = (from + 1) % numPorts;
    while (r != to)
    begin
      hit = hit | m[r];
      r = (r + 1) % numPorts;
    end
    return hit;
  endfunction

  function automatic logic allDelivered();
    logic done;
    done = (inValid == '0);
    for (int p = 0; p < numPorts; p++)
      done = done && (expQ[p].size() == 0);
    return done;
  endfunction

  // Head with length 1..6, then body flits, then a tail
  task automatic driveInputs();
    int len;
    for (int p = 0; p < numPorts; p++)
    begin
      if (!inValid[p] || taken[p])  // A held flit waits for ready
      begin
        inValid[p] = 1'b0;
        if (genOn && ({$random(seed)} % 10) < 3)
        begin
          if (left[p] == 0)
          begin
            len = 1 + int'({$random(seed)} % 6);
            inId[p] = idHead;
            inData[p] = {portIdx'(p), 1'b0, holdLen'(len)};
            left[p] = len;
          end
          else
          begin
            left[p] = left[p] - 1;
            inId[p] = (left[p] == 0) ? idTail : idBody;
            inData[p] = {portIdx'(p), seqNo[p]};
            seqNo[p] = seqNo[p] + 13'd1;
          end
          inValid[p] = 1'b1;
        end
      end
    end
  endtask

  a_idleAfterReset: assert property (@(posedge clk) $fell(rst) |-> !outValid)
    else reportMismatch("outValid high on the first cycle after reset");

  // Scoreboard and arbitration checks, sampled mid-cycle
  always @(negedge clk)
  begin
    logic [numPorts-1:0] mask;
    logic [numPorts-1:0] others;
    logic [18:0]         want;
    int                  src;
    if (!rst)
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        mask[p] = (occ[p] != 0);
        assert (inReady[p] == (occ[p] < fifoDepth))
          else reportMismatch($sformatf("port %0d inReady %0b with %0d flits queued",
                                        p, inReady[p], occ[p]));
      end
      assert (!outValid || mask != '0)
        else reportMismatch("outValid high while every FIFO is empty");
      if (!outReady)
      begin
        stalled = 1'b1;
        runLen = 0;
        headInRun = 1'b0;
      end
      if (outValid && outReady)
      begin
        src = int'(outData[15:13]);
        assert (src < numPorts && expQ[src].size() != 0)
          else reportMismatch($sformatf("unexpected flit %h from port %0d", outData, src));
        want = expQ[src].pop_front();
        assert ({outId, outData} == want)
          else reportMismatch($sformatf("port %0d sent %h, expected %h",
                                        src, {outId, outData}, want));
        if (src != lastSrc)
        begin
          if (!stalled && lastSrc == numPorts)
            assert (!skipped(numPorts - 1, src, prevMask))  // Local first from idle
              else reportMismatch($sformatf("port %0d granted first over a lower port", src));
          else if (!stalled)
            assert (!skipped(lastSrc, src, lastMask))
              else reportMismatch($sformatf("port %0d followed port %0d out of turn",
                                            src, lastSrc));
          runLen = 0;
          headInRun = 1'b0;
        end
        // Later heads reload the budget but the run still ends at the first one's limit
        if (outId == idHead && !headInRun)
        begin
          runLen = 0;
          headInRun = 1'b1;
          headLen[src] = outData[11:0];
        end
        runLen = runLen + 1;
        if (headInRun)
          assert (runLen <= int'(headLen[src]) + 2)
            else reportMismatch($sformatf("port %0d held the output for %0d flits, length %0d",
                                          src, runLen, headLen[src]));
        lastSrc = src;
        lastMask = mask;
        stalled = 1'b0;
        occ[src] = occ[src] - 1;
      end
      others = mask;
      if (lastSrc < numPorts)
        others[lastSrc] = 1'b0;
      if (others == '0)
      begin
        runLen = 0;  // Grant may lapse through idle
        headInRun = 1'b0;
      end
      for (int p = 0; p < numPorts; p++)
      begin
        taken[p] = inValid[p] && inReady[p];
        if (taken[p])
        begin
          expQ[p].push_back({inId[p], inData[p]});
          occ[p] = occ[p] + 1;
        end
      end
      prevMask = mask;
    end
  end

  initial
  begin
    int waited;
    seed = 18927;
    rst = 1'b1;
    outReady = 1'b1;
    inValid = '0;
    genOn = 1'b0;
    taken = '0;
    lastMask = '0;
    prevMask = '0;
    lastSrc = numPorts;  // No source yet
    runLen = 0;
    headInRun = 1'b0;
    stalled = 1'b0;
    for (int p = 0; p < numPorts; p++)
    begin
      inId[p] = '0;
      inData[p] = '0;
      left[p] = 0;
      seqNo[p] = '0;
      occ[p] = 0;
      headLen[p] = '0;
    end
    repeat (8) @(posedge clk);
    #5 rst = 1'b0;
    genOn = 1'b1;
    for (int cyc = 0; cyc < 1300; cyc++)
    begin
      @(posedge clk);
      #5;
      if (cyc >= 400 && cyc < 900)
        outReady = (({$random(seed)} % 2) == 0);  // Back-pressure phase
      else
        outReady = 1'b1;
      driveInputs();
    end
    genOn = 1'b0;
    outReady = 1'b1;
    waited = 0;
    while (!allDelivered() && waited < 2000)
    begin
      @(posedge clk);
      #5;
      driveInputs();
      waited++;
    end
    if (!allDelivered())
      endRun("Timeout: sent flits did not all reach the output");
    @(negedge clk);
    if (!outValid)
    begin
      $display("PASS: all tests");
      $finish;
    end
    else
      reportMismatch("outValid still high after the drain");
  end

endmodule

`default_nettype wire
